//--- Makefile
# Verilator simulation of the VITA transmit subsystem

LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -f sources.f --top-module tb_vita_tx -o sim_tb --Mdir obj_dir
	./obj_dir/sim_tb | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- source/vita_cfg_pkg.sv
package vita_cfg_pkg;

   typedef logic [7:0] apb_addr_t;

   localparam apb_addr_t REG_CTRL       = 8'h00;  // Bit 0 soft clear
   localparam apb_addr_t REG_POLICY     = 8'h04;
   localparam apb_addr_t REG_TIME_HI    = 8'h08;
   localparam apb_addr_t REG_TIME_LO    = 8'h0C;  // Write loads the counter
   localparam apb_addr_t REG_STATUS     = 8'h10;  // Read pops
   localparam apb_addr_t REG_STATUS_CNT = 8'h14;

   // Error policy bits
   localparam int POLICY_WAIT        = 0;
   localparam int POLICY_NEXT_PACKET = 1;
   localparam int POLICY_NEXT_BURST  = 2;

endpackage

//--- source/vita_tx_control.sv
`timescale 1ns/1ps

module vita_tx_control
#(
   parameter int IDLE_TIMEOUT = 1000
)
(
   input  logic                       clk,
   input  logic                       arst_n_i,
   input  logic                       soft_clear_i,
   input  vita_tx_pkg::vtime_t        vita_time_i,
   input  logic [2:0]                 policy_i,
   input  vita_tx_pkg::sample_t       ent_sample_i,
   input  vita_tx_pkg::vtime_t        ent_time_i,
   input  vita_tx_pkg::seqnum_t       ent_seqnum_i,
   input  logic                       ent_eop_i,
   input  logic                       ent_eob_i,
   input  logic                       ent_sob_i,
   input  logic                       ent_send_at_i,
   input  logic                       ent_seq_err_i,
   input  logic                       ent_valid_i,
   output logic                       ent_ready_o,
   input  logic                       strobe_i,
   output vita_tx_pkg::sample_t       sample_o,
   output logic                       run_o,
   output logic                       evt_valid_o,
   output vita_tx_pkg::status_code_t  evt_code_o
);

   typedef enum logic [2:0] {
      st_idle, st_run, st_cont_burst, st_error, st_done, st_wait
   } state_t;

   localparam int CW = $clog2(IDLE_TIMEOUT + 1);

   state_t        state;
   state_t        state_d;
   logic          evt_d;
   logic [15:0]   kind_d;
   logic          now;
   logic          late;
   logic          late_del;
   logic          late_qual;
   logic          pol_wait;
   logic          pol_next_packet;
   logic          pol_next_burst;
   logic          run_q;
   logic [CW-1:0] countdown;

   assign now  = (vita_time_i == ent_time_i);
   assign late = (vita_time_i > ent_time_i);

   assign pol_wait        = policy_i[vita_cfg_pkg::POLICY_WAIT];
   assign pol_next_packet = policy_i[vita_cfg_pkg::POLICY_NEXT_PACKET];
   assign pol_next_burst  = policy_i[vita_cfg_pkg::POLICY_NEXT_BURST];

   always_comb
   begin
      state_d = state;
      evt_d   = 1'b0;
      kind_d  = vita_tx_pkg::KIND_EOB_ACK;
      case (state)
         st_idle:
            if (ent_valid_i)
            begin
               if (ent_seq_err_i)
               begin
                  state_d = st_error;
                  evt_d   = 1'b1;
                  kind_d  = vita_tx_pkg::KIND_SEQ_ERROR;
               end
               else if (!ent_send_at_i || now)
                  state_d = st_run;
               else if (late && late_del && late_qual)
               begin
                  state_d = st_error;
                  evt_d   = 1'b1;
                  kind_d  = vita_tx_pkg::KIND_TIME_ERROR;
               end
            end
         st_run:
            if (strobe_i)
            begin
               if (!ent_valid_i)
               begin
                  state_d = st_error;
                  evt_d   = 1'b1;
                  kind_d  = vita_tx_pkg::KIND_UNDERRUN_MIDPKT;
               end
               else if (ent_eop_i && ent_eob_i)
               begin
                  state_d = st_done;  // Ack the completed burst
                  evt_d   = 1'b1;
               end
               else if (ent_eop_i)
                  state_d = st_cont_burst;
            end
         st_cont_burst:
            if (strobe_i)
            begin
               evt_d  = 1'b1;
               kind_d = vita_tx_pkg::KIND_UNDERRUN;
               if (pol_next_packet)
                  state_d = st_done;
               else if (pol_wait)
                  state_d = st_wait;
               else
                  state_d = st_error;
            end
            else if (ent_valid_i)
            begin
               // New burst before eob counts as mid-burst error too
               if (ent_seq_err_i || ent_sob_i)
               begin
                  state_d = st_error;
                  evt_d   = 1'b1;
                  kind_d  = vita_tx_pkg::KIND_SEQ_ERROR_MIDBURST;
               end
               else
                  state_d = st_run;
            end
         st_error:
            if (ent_valid_i && ent_eop_i)
            begin
               if (pol_next_packet || (pol_next_burst && ent_eob_i))
                  state_d = st_idle;
               else if (pol_wait)
                  state_d = st_wait;
            end
         st_done:
            state_d = st_idle;
         st_wait:
            state_d = st_wait;  // Left only by soft clear
         default:
            state_d = st_idle;
      endcase
   end

   assign ent_ready_o = (state == st_error) | (strobe_i & (state == st_run));
   assign sample_o    = (state == st_run) ? ent_sample_i : '0;
   assign run_o       = (state == st_run) | run_q;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state       <= st_idle;
         evt_valid_o <= 1'b0;
         late_del    <= 1'b0;
         late_qual   <= 1'b0;
      end
      else if (soft_clear_i)
      begin
         state       <= st_idle;
         evt_valid_o <= 1'b0;
         late_del    <= 1'b0;
         late_qual   <= 1'b0;
      end
      else
      begin
         state       <= state_d;
         evt_valid_o <= evt_d;
         late_del    <= late;
         late_qual   <= ent_valid_i & ~ent_ready_o;  // Entry held back
      end
   end

   always_ff @(posedge clk)
   begin
      if (evt_d)
         evt_code_o <= {ent_seqnum_i, kind_d};
   end

   // Keeps the DSP running across short gaps
   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         run_q     <= 1'b0;
         countdown <= '0;
      end
      else if (soft_clear_i)
      begin
         run_q     <= 1'b0;
         countdown <= '0;
      end
      else if (state == st_run)
      begin
         if (strobe_i && ent_valid_i && ent_eop_i && ent_eob_i)
            run_q <= 1'b0;  // Last sample of the burst
         else
         begin
            run_q     <= 1'b1;
            countdown <= CW'(IDLE_TIMEOUT);
         end
      end
      else if (countdown == '0)
         run_q <= 1'b0;
      else
         countdown <= countdown - 1'b1;
   end

endmodule

//--- source/vita_tx_deframer.sv
`timescale 1ns/1ps

module vita_tx_deframer
(
   input  logic                  clk,
   input  logic                  arst_n_i,
   input  logic                  soft_clear_i,
   input  logic [31:0]           in_data_i,
   input  logic                  in_eop_i,
   input  logic                  in_valid_i,
   output logic                  in_ready_o,
   output vita_tx_pkg::sample_t  ent_sample_o,
   output vita_tx_pkg::vtime_t   ent_time_o,
   output vita_tx_pkg::seqnum_t  ent_seqnum_o,
   output logic                  ent_eop_o,
   output logic                  ent_eob_o,
   output logic                  ent_sob_o,
   output logic                  ent_send_at_o,
   output logic                  ent_seq_err_o,
   output logic                  ent_valid_o,
   input  logic                  ent_ready_i
);

   typedef enum logic [1:0] {st_header, st_time_hi, st_time_lo, st_payload} state_t;

   state_t               state;
   logic                 ready_en;   // Low for one cycle after reset or clear
   logic                 first_q;
   logic                 in_fire;
   logic                 load;
   vita_tx_pkg::seqnum_t hdr_seq;
   vita_tx_pkg::seqnum_t expect_q;

   // Fields of the packet being parsed
   vita_tx_pkg::seqnum_t pkt_seq;
   vita_tx_pkg::vtime_t  pkt_time;
   logic                 pkt_send_at;
   logic                 pkt_sob;
   logic                 pkt_eob;
   logic                 pkt_seq_err;

   assign in_ready_o = ready_en & ~soft_clear_i &
                       ((state != st_payload) | ~ent_valid_o | ent_ready_i);
   assign in_fire    = in_valid_i & in_ready_o;
   assign load       = in_fire & (state == st_payload);
   assign hdr_seq    = in_data_i[vita_tx_pkg::HDR_SEQ_LSB +: 16];

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state       <= st_header;
         ready_en    <= 1'b0;
         first_q     <= 1'b1;
         expect_q    <= '0;
         ent_valid_o <= 1'b0;
      end
      else if (soft_clear_i)
      begin
         state       <= st_header;
         ready_en    <= 1'b0;
         first_q     <= 1'b1;
         ent_valid_o <= 1'b0;
      end
      else
      begin
         ready_en <= 1'b1;
         if (load)
            ent_valid_o <= 1'b1;
         else if (ent_ready_i)
            ent_valid_o <= 1'b0;
         if (in_fire)
         begin
            case (state)
               st_header:
               begin
                  first_q  <= 1'b0;
                  expect_q <= hdr_seq + 16'd1;
                  if (in_eop_i)
                     state <= st_header;  // Empty packet
                  else if (in_data_i[vita_tx_pkg::HDR_SEND_AT_BIT])
                     state <= st_time_hi;
                  else
                     state <= st_payload;
               end
               st_time_hi: state <= st_time_lo;
               st_time_lo: state <= st_payload;
               default:
                  if (in_eop_i)
                     state <= st_header;
            endcase
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (in_fire && state == st_header)
      begin
         pkt_seq     <= hdr_seq;
         pkt_send_at <= in_data_i[vita_tx_pkg::HDR_SEND_AT_BIT];
         pkt_sob     <= in_data_i[vita_tx_pkg::HDR_SOB_BIT];
         pkt_eob     <= in_data_i[vita_tx_pkg::HDR_EOB_BIT];
         pkt_seq_err <= ~first_q & (hdr_seq != expect_q);
      end
      if (in_fire && state == st_time_hi)
         pkt_time[63:32] <= in_data_i;
      if (in_fire && state == st_time_lo)
         pkt_time[31:0] <= in_data_i;
      if (load)
      begin
         ent_sample_o  <= in_data_i;
         ent_time_o    <= pkt_time;
         ent_seqnum_o  <= pkt_seq;
         ent_eop_o     <= in_eop_i;
         ent_eob_o     <= pkt_eob;
         ent_sob_o     <= pkt_sob;
         ent_send_at_o <= pkt_send_at;
         ent_seq_err_o <= pkt_seq_err;
      end
   end

endmodule

//--- source/vita_tx_pkg.sv
package vita_tx_pkg;

   typedef logic [31:0] sample_t;
   typedef logic [63:0] vtime_t;
   typedef logic [15:0] seqnum_t;

   // Upper half sequence number, lower half one-hot kind
   typedef logic [31:0] status_code_t;

   // Header word layout
   localparam int HDR_SEQ_LSB     = 0;
   localparam int HDR_SEND_AT_BIT = 16;
   localparam int HDR_SOB_BIT     = 17;
   localparam int HDR_EOB_BIT     = 18;

   localparam logic [15:0] KIND_EOB_ACK            = 16'd1;
   localparam logic [15:0] KIND_UNDERRUN           = 16'd2;  // Gap between packets of a burst
   localparam logic [15:0] KIND_SEQ_ERROR          = 16'd4;
   localparam logic [15:0] KIND_TIME_ERROR         = 16'd8;  // Send time already past
   localparam logic [15:0] KIND_UNDERRUN_MIDPKT    = 16'd16;
   localparam logic [15:0] KIND_SEQ_ERROR_MIDBURST = 16'd32;

endpackage

//--- source/vita_tx_regs.sv
`timescale 1ns/1ps

module vita_tx_regs
(
   input  logic                       clk,
   input  logic                       arst_n_i,
   input  logic                       psel_i,
   input  logic                       penable_i,
   input  logic                       pwrite_i,
   input  vita_cfg_pkg::apb_addr_t    paddr_i,
   input  logic [31:0]                pwdata_i,
   output logic [31:0]                prdata_o,
   output logic                       pready_o,
   output logic                       pslverr_o,
   output logic                       soft_clear_o,
   output logic [2:0]                 policy_o,
   output vita_tx_pkg::vtime_t        vita_time_o,
   output logic                       pop_o,
   input  vita_tx_pkg::status_code_t  head_code_i,
   input  logic [7:0]                 count_i,
   input  logic                       overflow_i
);

   logic        access;
   logic        wr;
   logic        mapped;
   logic        read_only;
   logic [31:0] time_hi_q;

   assign access   = psel_i & penable_i;
   assign wr       = access & pwrite_i;
   assign pready_o = 1'b1;

   always_comb
   begin
      mapped    = 1'b1;
      read_only = 1'b0;
      prdata_o  = '0;
      case (paddr_i)
         vita_cfg_pkg::REG_CTRL:
            prdata_o = '0;  // Soft clear reads as 0
         vita_cfg_pkg::REG_POLICY:
            prdata_o = {29'd0, policy_o};
         vita_cfg_pkg::REG_TIME_HI:
            prdata_o = vita_time_o[63:32];
         vita_cfg_pkg::REG_TIME_LO:
            prdata_o = vita_time_o[31:0];
         vita_cfg_pkg::REG_STATUS:
         begin
            read_only = 1'b1;
            prdata_o  = (count_i != 8'd0) ? head_code_i : '0;
         end
         vita_cfg_pkg::REG_STATUS_CNT:
         begin
            read_only = 1'b1;
            prdata_o  = {overflow_i, 23'd0, count_i};
         end
         default:
            mapped = 1'b0;
      endcase
   end

   assign pslverr_o = access & (~mapped | (pwrite_i & read_only));
   assign pop_o     = access & ~pwrite_i & (paddr_i == vita_cfg_pkg::REG_STATUS);

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         policy_o     <= '0;
         time_hi_q    <= '0;
         vita_time_o  <= '0;
         soft_clear_o <= 1'b0;
      end
      else
      begin
         soft_clear_o <= wr & (paddr_i == vita_cfg_pkg::REG_CTRL) & pwdata_i[0];
         if (wr && paddr_i == vita_cfg_pkg::REG_POLICY)
            policy_o <= pwdata_i[2:0];
         if (wr && paddr_i == vita_cfg_pkg::REG_TIME_HI)
            time_hi_q <= pwdata_i;
         if (wr && paddr_i == vita_cfg_pkg::REG_TIME_LO)
            vita_time_o <= {time_hi_q, pwdata_i};
         else
            vita_time_o <= vita_time_o + 64'd1;
      end
   end

endmodule

//--- source/vita_tx_status.sv
`timescale 1ns/1ps

module vita_tx_status
#(
   parameter int STATUS_DEPTH = 8
)
(
   input  logic                       clk,
   input  logic                       arst_n_i,
   input  logic                       soft_clear_i,
   input  logic                       evt_valid_i,
   input  vita_tx_pkg::status_code_t  evt_code_i,
   input  logic                       pop_i,
   output vita_tx_pkg::status_code_t  head_code_o,
   output logic [7:0]                 count_o,
   output logic                       overflow_o,
   output logic                       irq_o
);

   localparam int AW = $clog2(STATUS_DEPTH);

   vita_tx_pkg::status_code_t mem [STATUS_DEPTH];
   logic [AW-1:0]             wr_ptr;
   logic [AW-1:0]             rd_ptr;
   logic [AW:0]               cnt;
   logic                      full;
   logic                      push;
   logic                      pop;

   assign full = (cnt == (AW + 1)'(STATUS_DEPTH));
   assign push = evt_valid_i & ~full;
   assign pop  = pop_i & (cnt != '0);

   assign head_code_o = mem[rd_ptr];
   assign count_o     = 8'(cnt);
   assign irq_o       = (cnt != '0);

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         cnt        <= '0;
         overflow_o <= 1'b0;
      end
      else if (soft_clear_i)
      begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         cnt        <= '0;
         overflow_o <= 1'b0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;  // Wraps, depth is a power of two
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         if (push && !pop)
            cnt <= cnt + 1'b1;
         else if (pop && !push)
            cnt <= cnt - 1'b1;
         if (evt_valid_i && full)
            overflow_o <= 1'b1;  // Code dropped
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= evt_code_i;
   end

endmodule

//--- source/vita_tx_top.sv
`timescale 1ns/1ps

module vita_tx_top
#(
   parameter int IDLE_TIMEOUT = 1000,
   parameter int STATUS_DEPTH = 8
)
(
   input  logic                     clk,
   input  logic                     arst_n_i,
   input  logic                     psel_i,
   input  logic                     penable_i,
   input  logic                     pwrite_i,
   input  vita_cfg_pkg::apb_addr_t  paddr_i,
   input  logic [31:0]              pwdata_i,
   output logic [31:0]              prdata_o,
   output logic                     pready_o,
   output logic                     pslverr_o,
   input  logic [31:0]              in_data_i,
   input  logic                     in_eop_i,
   input  logic                     in_valid_i,
   output logic                     in_ready_o,
   input  logic                     strobe_i,
   output vita_tx_pkg::sample_t     sample_o,
   output logic                     run_o,
   output logic                     irq_o
);

   logic                      soft_clear;
   logic [2:0]                policy;
   vita_tx_pkg::vtime_t       vita_time;
   logic                      pop;
   vita_tx_pkg::status_code_t head_code;
   logic [7:0]                count;
   logic                      overflow;

   // Deframer to control
   vita_tx_pkg::sample_t      ent_sample;
   vita_tx_pkg::vtime_t       ent_time;
   vita_tx_pkg::seqnum_t      ent_seqnum;
   logic                      ent_eop;
   logic                      ent_eob;
   logic                      ent_sob;
   logic                      ent_send_at;
   logic                      ent_seq_err;
   logic                      ent_valid;
   logic                      ent_ready;

   logic                      evt_valid;
   vita_tx_pkg::status_code_t evt_code;

   vita_tx_regs u_regs
   (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .psel_i       (psel_i),
      .penable_i    (penable_i),
      .pwrite_i     (pwrite_i),
      .paddr_i      (paddr_i),
      .pwdata_i     (pwdata_i),
      .prdata_o     (prdata_o),
      .pready_o     (pready_o),
      .pslverr_o    (pslverr_o),
      .soft_clear_o (soft_clear),
      .policy_o     (policy),
      .vita_time_o  (vita_time),
      .pop_o        (pop),
      .head_code_i  (head_code),
      .count_i      (count),
      .overflow_i   (overflow)
   );

   vita_tx_deframer u_deframer
   (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .soft_clear_i  (soft_clear),
      .in_data_i     (in_data_i),
      .in_eop_i      (in_eop_i),
      .in_valid_i    (in_valid_i),
      .in_ready_o    (in_ready_o),
      .ent_sample_o  (ent_sample),
      .ent_time_o    (ent_time),
      .ent_seqnum_o  (ent_seqnum),
      .ent_eop_o     (ent_eop),
      .ent_eob_o     (ent_eob),
      .ent_sob_o     (ent_sob),
      .ent_send_at_o (ent_send_at),
      .ent_seq_err_o (ent_seq_err),
      .ent_valid_o   (ent_valid),
      .ent_ready_i   (ent_ready)
   );

   vita_tx_control #(.IDLE_TIMEOUT(IDLE_TIMEOUT)) u_control
   (
      .clk           (clk),
      .arst_n_i      (arst_n_i),
      .soft_clear_i  (soft_clear),
      .vita_time_i   (vita_time),
      .policy_i      (policy),
      .ent_sample_i  (ent_sample),
      .ent_time_i    (ent_time),
      .ent_seqnum_i  (ent_seqnum),
      .ent_eop_i     (ent_eop),
      .ent_eob_i     (ent_eob),
      .ent_sob_i     (ent_sob),
      .ent_send_at_i (ent_send_at),
      .ent_seq_err_i (ent_seq_err),
      .ent_valid_i   (ent_valid),
      .ent_ready_o   (ent_ready),
      .strobe_i      (strobe_i),
      .sample_o      (sample_o),
      .run_o         (run_o),
      .evt_valid_o   (evt_valid),
      .evt_code_o    (evt_code)
   );

   vita_tx_status #(.STATUS_DEPTH(STATUS_DEPTH)) u_status
   (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .soft_clear_i (soft_clear),
      .evt_valid_i  (evt_valid),
      .evt_code_i   (evt_code),
      .pop_i        (pop),
      .head_code_o  (head_code),
      .count_o      (count),
      .overflow_o   (overflow),
      .irq_o        (irq_o)
   );

endmodule

//--- sources.f
source/vita_tx_pkg.sv
source/vita_cfg_pkg.sv
source/vita_tx_regs.sv
source/vita_tx_deframer.sv
source/vita_tx_control.sv
source/vita_tx_status.sv
source/vita_tx_top.sv
test/tb_vita_tx.sv

//--- test/tb_vita_tx.sv
`timescale 1ns/1ps

module tb_vita_tx;

   logic        clk = 1'b0;
   logic        arst_n_i;
   logic        psel_i;
   logic        penable_i;
   logic        pwrite_i;
   logic [7:0]  paddr_i;
   logic [31:0] pwdata_i;
   logic [31:0] prdata_o;
   logic        pready_o;
   logic        pslverr_o;
   logic [31:0] in_data_i;
   logic        in_eop_i;
   logic        in_valid_i;
   logic        in_ready_o;
   logic        strobe_i;
   logic [31:0] sample_o;
   logic        run_o;
   logic        irq_o;

   integer      seed = 32'hd7da;
   int          strobe_mode;   // 0 random, 1 held on, 2 held off
   logic        check_en;
   int          pkts;
   int          cycles;
   string       test_name;
   time         t_load;
   time         first_out_t;
   logic [31:0] exp_q[$];

   vita_tx_top #(.IDLE_TIMEOUT(50)) u_dut
   (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .psel_i     (psel_i),
      .penable_i  (penable_i),
      .pwrite_i   (pwrite_i),
      .paddr_i    (paddr_i),
      .pwdata_i   (pwdata_i),
      .prdata_o   (prdata_o),
      .pready_o   (pready_o),
      .pslverr_o  (pslverr_o),
      .in_data_i  (in_data_i),
      .in_eop_i   (in_eop_i),
      .in_valid_i (in_valid_i),
      .in_ready_o (in_ready_o),
      .strobe_i   (strobe_i),
      .sample_o   (sample_o),
      .run_o      (run_o),
      .irq_o      (irq_o)
   );

   always #20 clk = ~clk;

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
      assert (exp === act)
      else
         abort_run($sformatf("MISMATCH %s %s expected %h actual %h", test_name, what, exp, act));
   endtask

   // Expected code with the sequence number in the upper half and kind below
   function automatic logic [31:0] ref_code(input logic [15:0] seq, input logic [15:0] kind);
      return 32'(seq) * 32'd65536 + 32'(kind);
   endfunction

   // Sample words are never zero so they stand out from an idle sample_o
   function automatic logic [31:0] ref_sample(input logic [15:0] seq, input int idx);
      return {1'b1, seq[14:0], 16'(idx + 1)};
   endfunction

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
      @(posedge clk);
      #2 psel_i = 1'b1;
      pwrite_i  = 1'b1;
      paddr_i   = addr;
      pwdata_i  = data;
      @(posedge clk);
      #2 penable_i = 1'b1;
      @(negedge clk);
      err = pslverr_o;
      check_val("pready_o on write", 32'd1, 32'(pready_o));
      @(posedge clk);
      t_load = $time;
      #2 psel_i = 1'b0;
      penable_i = 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
      @(posedge clk);
      #2 psel_i = 1'b1;
      pwrite_i  = 1'b0;
      paddr_i   = addr;
      @(posedge clk);
      #2 penable_i = 1'b1;
      @(negedge clk);
      data = prdata_o;
      err  = pslverr_o;
      check_val("pready_o on read", 32'd1, 32'(pready_o));
      @(posedge clk);
      #2 psel_i = 1'b0;
      penable_i = 1'b0;
   endtask

   task automatic push_word(input logic [31:0] w, input logic eop);
      logic ok;
      in_data_i  = w;
      in_eop_i   = eop;
      in_valid_i = 1'b1;
      do
      begin
         @(negedge clk);
         ok = in_ready_o;
         @(posedge clk);
         #2;
      end
      while (!ok);
      in_valid_i = 1'b0;
   endtask

   // Sends one packet and queues its samples when they are expected to leave
   task automatic send_packet(input logic [15:0] seq, input int nsamp, input logic sob,
                              input logic eob, input logic send_at, input logic [63:0] t,
                              input logic expect_out, input int stall_at);
      pkts++;
      @(posedge clk);
      #2;
      push_word({13'd0, eob, sob, send_at, seq}, 1'b0);
      if (send_at)
      begin
         push_word(t[63:32], 1'b0);
         push_word(t[31:0], 1'b0);
      end
      for (int i = 0; i < nsamp; i++)
      begin
         if (i == stall_at)
         begin
            repeat (10) @(posedge clk);  // Input stalls mid-packet
            #2;
         end
         if (expect_out)
            exp_q.push_back(ref_sample(seq, i));
         push_word(ref_sample(seq, i), i == nsamp - 1);
      end
   endtask

   task automatic wait_count(input int n);
      logic [31:0] rd;
      logic        err;
      do
         apb_read(vita_cfg_pkg::REG_STATUS_CNT, rd, err);
      while (rd[7:0] != 8'(n));
   endtask

   task automatic expect_code(input logic [31:0] exp);
      logic [31:0] rd;
      logic        err;
      apb_read(vita_cfg_pkg::REG_STATUS, rd, err);
      check_val("status code", exp, rd);
   endtask

   always @(posedge clk)
   begin
      #2;
      if (strobe_mode == 1)
         strobe_i <= 1'b1;
      else if (strobe_mode == 2)
         strobe_i <= 1'b0;
      else
         strobe_i <= (($random(seed) & 3) != 0);
   end

   // Zero on sample_o means control is outside its run state
   always @(negedge clk)
   begin
      if (check_en && arst_n_i && strobe_i && run_o && sample_o != 32'd0)
      begin
         assert (exp_q.size() > 0)
         else
            abort_run($sformatf("%s: a sample left when none was expected", test_name));
         check_val("sample", exp_q[0], sample_o);
         void'(exp_q.pop_front());
         if (first_out_t == 0)
            first_out_t = $time;
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles > 400 * pkts + 2000)
         abort_run("Watchdog expired, the DUT stopped making progress");
   end

   initial
   begin
      logic [31:0] rd;
      logic        err;
      arst_n_i    = 1'b0;
      psel_i      = 1'b0;
      penable_i   = 1'b0;
      pwrite_i    = 1'b0;
      paddr_i     = '0;
      pwdata_i    = '0;
      in_data_i   = '0;
      in_eop_i    = 1'b0;
      in_valid_i  = 1'b0;
      strobe_i    = 1'b0;
      strobe_mode = 0;
      check_en    = 1'b1;
      pkts        = 0;
      cycles      = 0;
      first_out_t = 0;
      test_name   = "reset";
      repeat (4) @(posedge clk);
      #2 arst_n_i = 1'b1;
      apb_write(vita_cfg_pkg::REG_POLICY, 32'd2, err);  // Next packet

      test_name = "bursts";
      send_packet(16'd0, 4, 1'b1, 1'b1, 1'b0, 64'd0, 1'b1, -1);
      send_packet(16'd1, 3, 1'b1, 1'b1, 1'b0, 64'd0, 1'b1, -1);
      send_packet(16'd2, 5, 1'b1, 1'b1, 1'b0, 64'd0, 1'b1, -1);
      wait_count(3);
      for (int s = 0; s < 3; s++)
         expect_code(ref_code(16'(s), vita_tx_pkg::KIND_EOB_ACK));
      check_val("samples left over", 32'd0, 32'(exp_q.size()));
      repeat (50) @(posedge clk);
      check_val("run_o after burst", 32'd0, 32'(run_o));

      test_name = "timed";
      apb_write(vita_cfg_pkg::REG_TIME_HI, 32'd0, err);
      apb_write(vita_cfg_pkg::REG_TIME_LO, 32'd100, err);
      first_out_t = 0;
      send_packet(16'd3, 2, 1'b1, 1'b1, 1'b1, 64'd250, 1'b1, -1);
      wait_count(1);
      expect_code(ref_code(16'd3, vita_tx_pkg::KIND_EOB_ACK));
      assert (first_out_t >= t_load + 150 * 40)
      else
         abort_run("A timed sample left before its send time");
      send_packet(16'd4, 2, 1'b1, 1'b1, 1'b1, 64'd10, 1'b0, -1);
      wait_count(1);
      expect_code(ref_code(16'd4, vita_tx_pkg::KIND_TIME_ERROR));

      test_name = "sequence gap";
      send_packet(16'd6, 3, 1'b1, 1'b1, 1'b0, 64'd0, 1'b0, -1);
      send_packet(16'd7, 3, 1'b1, 1'b1, 1'b0, 64'd0, 1'b1, -1);
      wait_count(2);
      expect_code(ref_code(16'd6, vita_tx_pkg::KIND_SEQ_ERROR));
      expect_code(ref_code(16'd7, vita_tx_pkg::KIND_EOB_ACK));

      // Stale samples show on sample_o during an underrun
      test_name   = "underrun";
      check_en    = 1'b0;
      strobe_mode = 1;
      send_packet(16'd8, 3, 1'b1, 1'b1, 1'b0, 64'd0, 1'b0, 1);
      wait_count(1);
      send_packet(16'd9, 2, 1'b1, 1'b0, 1'b0, 64'd0, 1'b0, -1);
      repeat (10) @(posedge clk);
      send_packet(16'd10, 2, 1'b0, 1'b1, 1'b0, 64'd0, 1'b0, -1);
      wait_count(3);
      expect_code(ref_code(16'd8, vita_tx_pkg::KIND_UNDERRUN_MIDPKT));
      expect_code(ref_code(16'd9, vita_tx_pkg::KIND_UNDERRUN));
      expect_code(ref_code(16'd10, vita_tx_pkg::KIND_EOB_ACK));
      strobe_mode = 2;
      exp_q.delete();
      check_en = 1'b1;

      test_name = "registers";
      apb_read(vita_cfg_pkg::REG_STATUS_CNT, rd, err);
      check_val("empty count", 32'd0, rd);
      check_val("irq_o when empty", 32'd0, 32'(irq_o));
      apb_write(vita_cfg_pkg::REG_POLICY, 32'd4, err);
      apb_read(vita_cfg_pkg::REG_POLICY, rd, err);
      check_val("policy readback", 32'd4, rd);
      apb_write(vita_cfg_pkg::REG_POLICY, 32'd2, err);
      apb_read(8'h20, rd, err);
      check_val("pslverr on unmapped read", 32'd1, 32'(err));
      apb_write(vita_cfg_pkg::REG_STATUS, 32'd5, err);
      check_val("pslverr on read-only write", 32'd1, 32'(err));
      strobe_mode = 0;
      for (int p = 0; p < 10; p++)
         send_packet(16'(11 + p), 1, 1'b1, 1'b1, 1'b0, 64'd0, 1'b1, -1);
      do
         apb_read(vita_cfg_pkg::REG_STATUS_CNT, rd, err);
      while (!(rd[31] && exp_q.size() == 0));
      repeat (3) @(posedge clk);  // Last code still in flight
      apb_read(vita_cfg_pkg::REG_STATUS_CNT, rd, err);
      check_val("full count with overflow", 32'h8000_0008, rd);
      check_val("irq_o when full", 32'd1, 32'(irq_o));
      apb_write(vita_cfg_pkg::REG_CTRL, 32'd1, err);
      apb_read(vita_cfg_pkg::REG_STATUS_CNT, rd, err);
      check_val("count after soft clear", 32'd0, rd);
      check_val("irq_o after soft clear", 32'd0, 32'(irq_o));

      $display("Simulation passed");
      $finish;
   end

endmodule
